// File: hdl/riscv_pkg.sv
// isa level constants and fetch exception cause codes, referenced by scoped name from rtl and tb
package riscv_pkg;

    // register and address width of the rv64 core
    parameter int unsigned XLEN = 64;

    // uncompressed instruction word only
    parameter int unsigned INST_WIDTH = 32;

    // mcause codes raised by instruction fetch
    // enum is full xlen wide so it lines up with the mcause csr
    typedef enum logic [XLEN-1:0] {
        // pc low bits not zero
        INSTR_ADDR_MISALIGNED = 64'd0,
        // pmp or bus error reported by the icache
        INSTR_ACCESS_FAULT    = 64'd1,
        // translation failed in the itlb
        INSTR_PAGE_FAULT      = 64'd12
    } exc_cause_e;

endpackage

// File: hdl/fetch_pkg.sv
// fetch microarchitecture definitions shared by the fetch rtl and its testbench
package fetch_pkg;

    // next pc choice driven by the control unit
    // code 2'b11 is never expected from the control unit
    typedef enum logic [1:0] {
        // keep current pc, used on stalls
        NEXT_PC_SEL_PC   = 2'b00,
        // sequential fetch
        NEXT_PC_SEL_PC_4 = 2'b01,
        // redirect from commit or decode
        NEXT_PC_SEL_JUMP = 2'b10
    } next_pc_sel_e;

    // virtual address bits seen by the icache and itlb
    parameter int unsigned VADDR_WIDTH = 40;

    // boot address after reset
    parameter logic [riscv_pkg::XLEN-1:0] RESET_PC_DEFAULT = 64'h0000_0000_0000_0200;

    // predictor table depth, power of two
    parameter int unsigned BPRED_ENTRIES_DEFAULT = 64;

endpackage

// File: hdl/branch_predictor.sv
// direct mapped 2-bit counter branch predictor, looked up by fetch and trained by execute
`timescale 1ns/100ps

module branch_predictor #(
    parameter int unsigned BPRED_ENTRIES = fetch_pkg::BPRED_ENTRIES_DEFAULT
) (
    input  logic                         clk_i,
    input  logic                         rstn_i,
    // lookup side, pc currently being fetched
    input  logic [riscv_pkg::XLEN-1:0]   pc_fetch_i,
    // training side from execute
    input  logic [riscv_pkg::XLEN-1:0]   pc_execution_i,
    input  logic                         branch_taken_result_exec_i,
    input  logic [riscv_pkg::XLEN-1:0]   branch_addr_result_exec_i,
    input  logic                         is_branch_exec_i,
    // prediction for the fetched pc
    output logic                         branch_predict_taken_o,
    output logic [riscv_pkg::XLEN-1:0]   branch_predict_addr_o
);

    // index bits taken just above the instruction byte offset
    localparam int unsigned IDX_WIDTH = $clog2(BPRED_ENTRIES);
    localparam int unsigned IDX_LSB   = 2;

    // saturating counter states, msb is the taken decision
    typedef enum logic [1:0] {
        CNT_STRONG_NT = 2'b00,
        CNT_WEAK_NT   = 2'b01,
        CNT_WEAK_T    = 2'b10,
        CNT_STRONG_T  = 2'b11
    } counter_e;

    // table storage
    counter_e                     counter_q [BPRED_ENTRIES];
    logic [riscv_pkg::XLEN-1:0]   target_q  [BPRED_ENTRIES];

    // lookup and training indices
    logic [IDX_WIDTH-1:0] idx_fetch;
    logic [IDX_WIDTH-1:0] idx_exec;

    // counter read for training and its updated value
    counter_e cnt_fetch;
    counter_e cnt_exec;
    counter_e cnt_next;

    // table depth must be a power of two, at least 2
    if ((BPRED_ENTRIES < 2) || ((BPRED_ENTRIES & (BPRED_ENTRIES - 1)) != 0)) begin : g_depth_check
        $error("branch predictor depth must be a power of two of at least 2");
    end

    assign idx_fetch = pc_fetch_i[IDX_LSB +: IDX_WIDTH];
    assign idx_exec  = pc_execution_i[IDX_LSB +: IDX_WIDTH];

    // combinational lookup
    assign cnt_fetch = counter_q[idx_fetch];
    assign cnt_exec  = counter_q[idx_exec];

    // predict taken on the upper counter bit
    assign branch_predict_taken_o = cnt_fetch[1];
    // stored target is returned whatever the decision
    assign branch_predict_addr_o  = target_q[idx_fetch];

    // saturating counter update
    always_comb begin
        cnt_next = cnt_exec;
        if (branch_taken_result_exec_i) begin
            // count up, stick at strong taken
            case (cnt_exec)
                CNT_STRONG_NT: cnt_next = CNT_WEAK_NT;
                CNT_WEAK_NT:   cnt_next = CNT_WEAK_T;
                default:       cnt_next = CNT_STRONG_T;
            endcase
        end else begin
            // count down, stick at strong not taken
            case (cnt_exec)
                CNT_STRONG_T:  cnt_next = CNT_WEAK_T;
                CNT_WEAK_T:    cnt_next = CNT_WEAK_NT;
                default:       cnt_next = CNT_STRONG_NT;
            endcase
        end
    end

    // counter table
    // reset to weakly not taken
    always_ff @(posedge clk_i, negedge rstn_i) begin
        if (!rstn_i) begin
            for (int i = 0; i < BPRED_ENTRIES; i++) begin
                counter_q[i] <= CNT_WEAK_NT;
            end
        end else if (is_branch_exec_i) begin
            counter_q[idx_exec] <= cnt_next;
        end
    end

    // target table
    // only a taken branch writes its target, not taken keeps the old one
    always_ff @(posedge clk_i, negedge rstn_i) begin
        if (!rstn_i) begin
            for (int i = 0; i < BPRED_ENTRIES; i++) begin
                target_q[i] <= '0;
            end
        end else if (is_branch_exec_i && branch_taken_result_exec_i) begin
            target_q[idx_exec] <= branch_addr_result_exec_i;
        end
    end

    // execute must never train a taken branch with a target fetch would flag as misaligned
    // otherwise a predicted redirect would land on a faulting pc
    assert property (@(posedge clk_i) disable iff (!rstn_i)
        (is_branch_exec_i && branch_taken_result_exec_i)
            |-> (branch_addr_result_exec_i[1:0] == 2'b00))
        else $error("taken branch trained with misaligned target");

endmodule

// File: hdl/if_stage.sv
// instruction fetch stage: pc register, next pc mux, icache request and fetch exceptions
`timescale 1ns/100ps

module if_stage #(
    parameter logic [riscv_pkg::XLEN-1:0] RESET_PC      = fetch_pkg::RESET_PC_DEFAULT,
    parameter int unsigned                BPRED_ENTRIES = fetch_pkg::BPRED_ENTRIES_DEFAULT
) (
    input  logic                                clk_i,
    input  logic                                rstn_i,
    // control unit
    input  logic                                stall_i,
    input  fetch_pkg::next_pc_sel_e             next_pc_sel_i,
    input  logic                                invalidate_icache_i,
    input  logic                                invalidate_buffer_i,
    // redirect from commit or decode
    input  logic [riscv_pkg::XLEN-1:0]          pc_jump_i,
    // icache response, same cycle as request
    input  logic                                icache_resp_valid_i,
    input  logic [riscv_pkg::INST_WIDTH-1:0]    icache_resp_data_i,
    input  logic                                icache_resp_access_fault_i,
    input  logic                                icache_resp_page_fault_i,
    // predictor training from execute
    input  logic                                exe_is_branch_i,
    input  logic [riscv_pkg::XLEN-1:0]          exe_pc_i,
    input  logic                                exe_taken_i,
    input  logic [riscv_pkg::XLEN-1:0]          exe_target_i,
    // icache request
    output logic                                icache_req_valid_o,
    output logic [fetch_pkg::VADDR_WIDTH-1:0]   icache_req_vaddr_o,
    output logic                                icache_req_invalidate_icache_o,
    output logic                                icache_req_invalidate_buffer_o,
    // towards decode
    output logic                                fetch_valid_o,
    output logic [riscv_pkg::XLEN-1:0]          fetch_pc_o,
    output logic [riscv_pkg::INST_WIDTH-1:0]    fetch_inst_o,
    output logic                                fetch_ex_valid_o,
    output riscv_pkg::exc_cause_e               fetch_ex_cause_o,
    output logic [riscv_pkg::XLEN-1:0]          fetch_ex_origin_o,
    output logic                                fetch_bpred_taken_o,
    output logic [riscv_pkg::XLEN-1:0]          fetch_bpred_target_o
);

    // sequential step, no compressed instructions
    localparam logic [riscv_pkg::XLEN-1:0] PC_STEP = 4;

    // current and next pc
    logic [riscv_pkg::XLEN-1:0] pc_q;
    logic [riscv_pkg::XLEN-1:0] next_pc;

    // raw exception flags
    logic ex_misaligned;
    logic ex_access_fault;
    logic ex_page_fault;

    // next pc mux
    // stall handling lives in the control unit, it selects NEXT_PC_SEL_PC
    always_comb begin
        case (next_pc_sel_i)
            fetch_pkg::NEXT_PC_SEL_PC:   next_pc = pc_q;
            fetch_pkg::NEXT_PC_SEL_PC_4: next_pc = pc_q + PC_STEP;
            fetch_pkg::NEXT_PC_SEL_JUMP: next_pc = pc_jump_i;
            // illegal code, keep fetching sequentially
            default:                     next_pc = pc_q + PC_STEP;
        endcase
    end

    // pc register, loads every edge
    always_ff @(posedge clk_i, negedge rstn_i) begin
        if (!rstn_i) begin
            pc_q <= RESET_PC;
        end else begin
            pc_q <= next_pc;
        end
    end

    // misaligned detected locally from the pc
    assign ex_misaligned   = |pc_q[1:0];
    // faults only count when the icache answers
    assign ex_access_fault = icache_resp_valid_i & icache_resp_access_fault_i;
    assign ex_page_fault   = icache_resp_valid_i & icache_resp_page_fault_i;

    // icache request
    // a misaligned pc is never sent to the cache
    assign icache_req_valid_o             = ~ex_misaligned & ~stall_i;
    assign icache_req_vaddr_o             = pc_q[fetch_pkg::VADDR_WIDTH-1:0];
    assign icache_req_invalidate_icache_o = invalidate_icache_i;
    assign icache_req_invalidate_buffer_o = invalidate_buffer_i;

    // exception ranking
    // misaligned first, then access fault, then page fault
    always_comb begin
        fetch_ex_valid_o = 1'b1;
        if (ex_misaligned) begin
            fetch_ex_cause_o = riscv_pkg::INSTR_ADDR_MISALIGNED;
        end else if (ex_access_fault) begin
            fetch_ex_cause_o = riscv_pkg::INSTR_ACCESS_FAULT;
        end else if (ex_page_fault) begin
            fetch_ex_cause_o = riscv_pkg::INSTR_PAGE_FAULT;
        end else begin
            fetch_ex_valid_o = 1'b0;
            fetch_ex_cause_o = riscv_pkg::INSTR_ADDR_MISALIGNED;
        end
    end

    // faulting pc goes out as the origin
    assign fetch_ex_origin_o = pc_q;

    // fetch output
    // an exception also makes the slot valid so decode sees it
    assign fetch_valid_o = icache_resp_valid_i | fetch_ex_valid_o;
    assign fetch_pc_o    = pc_q;
    assign fetch_inst_o  = icache_resp_data_i;

    // predictor, indexed by the fetch pc
    branch_predictor #(
        .BPRED_ENTRIES (BPRED_ENTRIES)
    ) branch_predictor_inst (
        .clk_i                      (clk_i),
        .rstn_i                     (rstn_i),
        .pc_fetch_i                 (pc_q),
        .pc_execution_i             (exe_pc_i),
        .branch_taken_result_exec_i (exe_taken_i),
        .branch_addr_result_exec_i  (exe_target_i),
        .is_branch_exec_i           (exe_is_branch_i),
        .branch_predict_taken_o     (fetch_bpred_taken_o),
        .branch_predict_addr_o      (fetch_bpred_target_o)
    );

    // control unit only issues the three defined selects once out of reset
    assert property (@(posedge clk_i) disable iff (!rstn_i)
        next_pc_sel_i inside {fetch_pkg::NEXT_PC_SEL_PC,
                              fetch_pkg::NEXT_PC_SEL_PC_4,
                              fetch_pkg::NEXT_PC_SEL_JUMP})
        else $error("illegal next pc select from control unit");

    // a misaligned jump target must not reach the icache on the following cycle
    assert property (@(posedge clk_i) disable iff (!rstn_i)
        (next_pc_sel_i == fetch_pkg::NEXT_PC_SEL_JUMP && |pc_jump_i[1:0])
            |=> !icache_req_valid_o)
        else $error("icache request issued for misaligned pc");

endmodule

// File: hdl/fetch_top.sv
// fetch subsystem top level, sets fetch parameters and exposes control, execute and icache ports
`timescale 1ns/100ps

module fetch_top #(
    // boot address
    parameter logic [riscv_pkg::XLEN-1:0] RESET_PC      = fetch_pkg::RESET_PC_DEFAULT,
    // predictor depth, power of two
    parameter int unsigned                BPRED_ENTRIES = fetch_pkg::BPRED_ENTRIES_DEFAULT
) (
    input  logic                                clk_i,
    input  logic                                rstn_i,
    // control unit
    input  logic                                stall_i,
    input  fetch_pkg::next_pc_sel_e             next_pc_sel_i,
    input  logic                                invalidate_icache_i,
    input  logic                                invalidate_buffer_i,
    // commit or decode redirect
    input  logic [riscv_pkg::XLEN-1:0]          pc_jump_i,
    // execute stage training
    input  logic                                exe_is_branch_i,
    input  logic [riscv_pkg::XLEN-1:0]          exe_pc_i,
    input  logic                                exe_taken_i,
    input  logic [riscv_pkg::XLEN-1:0]          exe_target_i,
    // icache request
    output logic                                icache_req_valid_o,
    output logic [fetch_pkg::VADDR_WIDTH-1:0]   icache_req_vaddr_o,
    output logic                                icache_req_invalidate_icache_o,
    output logic                                icache_req_invalidate_buffer_o,
    // icache response
    input  logic                                icache_resp_valid_i,
    input  logic [riscv_pkg::INST_WIDTH-1:0]    icache_resp_data_i,
    input  logic                                icache_resp_access_fault_i,
    input  logic                                icache_resp_page_fault_i,
    // fetch result towards decode
    output logic                                fetch_valid_o,
    output logic [riscv_pkg::XLEN-1:0]          fetch_pc_o,
    output logic [riscv_pkg::INST_WIDTH-1:0]    fetch_inst_o,
    output logic                                fetch_ex_valid_o,
    output riscv_pkg::exc_cause_e               fetch_ex_cause_o,
    output logic [riscv_pkg::XLEN-1:0]          fetch_ex_origin_o,
    output logic                                fetch_bpred_taken_o,
    output logic [riscv_pkg::XLEN-1:0]          fetch_bpred_target_o
);

    // fetch stage with its predictor
    if_stage #(
        .RESET_PC      (RESET_PC),
        .BPRED_ENTRIES (BPRED_ENTRIES)
    ) if_stage_inst (
        .clk_i                          (clk_i),
        .rstn_i                         (rstn_i),
        .stall_i                        (stall_i),
        .next_pc_sel_i                  (next_pc_sel_i),
        .invalidate_icache_i            (invalidate_icache_i),
        .invalidate_buffer_i            (invalidate_buffer_i),
        .pc_jump_i                      (pc_jump_i),
        .icache_resp_valid_i            (icache_resp_valid_i),
        .icache_resp_data_i             (icache_resp_data_i),
        .icache_resp_access_fault_i     (icache_resp_access_fault_i),
        .icache_resp_page_fault_i       (icache_resp_page_fault_i),
        .exe_is_branch_i                (exe_is_branch_i),
        .exe_pc_i                       (exe_pc_i),
        .exe_taken_i                    (exe_taken_i),
        .exe_target_i                   (exe_target_i),
        .icache_req_valid_o             (icache_req_valid_o),
        .icache_req_vaddr_o             (icache_req_vaddr_o),
        .icache_req_invalidate_icache_o (icache_req_invalidate_icache_o),
        .icache_req_invalidate_buffer_o (icache_req_invalidate_buffer_o),
        .fetch_valid_o                  (fetch_valid_o),
        .fetch_pc_o                     (fetch_pc_o),
        .fetch_inst_o                   (fetch_inst_o),
        .fetch_ex_valid_o               (fetch_ex_valid_o),
        .fetch_ex_cause_o               (fetch_ex_cause_o),
        .fetch_ex_origin_o              (fetch_ex_origin_o),
        .fetch_bpred_taken_o            (fetch_bpred_taken_o),
        .fetch_bpred_target_o           (fetch_bpred_target_o)
    );

endmodule

// File: testbench/tb_fetch_top.sv
// directed testbench for fetch_top, models the icache and the predictor and checks every output
`timescale 1ns/100ps

module tb_fetch_top;

    localparam int CLK_PERIOD   = 100;
    localparam int RESET_CYCLES = 8;
    localparam logic [63:0] RESET_PC = fetch_pkg::RESET_PC_DEFAULT;
    localparam int unsigned ENTRIES  = fetch_pkg::BPRED_ENTRIES_DEFAULT;
    localparam int unsigned IDX_WIDTH = $clog2(ENTRIES);
    localparam logic [63:0] ALIAS_STRIDE = 64'(ENTRIES * 4);
    localparam int ICACHE_WORDS = 16;

    // loop lengths of the directed tests
    localparam int N_SEQ  = 40;
    localparam int N_REQ  = 32;
    localparam int N_DATA = 16;
    localparam int N_RUNS = 24;
    // cycles per test, training runs are at most 5 steps long
    localparam int TEST_CYCLES = 2 * N_SEQ + 3 * N_REQ + 4 * N_DATA + 3 * 16
                               + 2 * (ENTRIES + 1) + 10 * N_RUNS;
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + TEST_CYCLES + 100;

    // dut inputs
    logic                    clk;
    logic                    rstn;
    logic                    stall;
    fetch_pkg::next_pc_sel_e next_pc_sel;
    logic                    inv_icache;
    logic                    inv_buffer;
    logic [63:0]             pc_jump;
    logic                    exe_is_branch;
    logic [63:0]             exe_pc;
    logic                    exe_taken;
    logic [63:0]             exe_target;
    logic                    resp_valid;
    logic [31:0]             resp_data;
    logic                    resp_access_fault;
    logic                    resp_page_fault;

    // dut outputs
    logic                    req_valid;
    logic [39:0]             req_vaddr;
    logic                    req_inv_icache;
    logic                    req_inv_buffer;
    logic                    fetch_valid;
    logic [63:0]             fetch_pc;
    logic [31:0]             fetch_inst;
    logic                    fetch_ex_valid;
    riscv_pkg::exc_cause_e   fetch_ex_cause;
    logic [63:0]             fetch_ex_origin;
    logic                    bpred_taken;
    logic [63:0]             bpred_target;

    // icache model state, flags forced per test
    logic [31:0] icache_mem [ICACHE_WORDS];
    logic        cache_valid;
    logic        cache_access_fault;
    logic        cache_page_fault;

    // reference state
    logic [63:0] ref_pc;
    logic [1:0]  ref_cnt [ENTRIES];
    logic [63:0] ref_tgt [ENTRIES];

    // combinational icache, answers the current request in the same cycle
    assign resp_valid        = cache_valid;
    assign resp_data         = icache_mem[req_vaddr[5:2]];
    assign resp_access_fault = cache_access_fault;
    assign resp_page_fault   = cache_page_fault;

    fetch_top #(
        .RESET_PC      (RESET_PC),
        .BPRED_ENTRIES (ENTRIES)
    ) DUT (
        .clk_i                          (clk),
        .rstn_i                         (rstn),
        .stall_i                        (stall),
        .next_pc_sel_i                  (next_pc_sel),
        .invalidate_icache_i            (inv_icache),
        .invalidate_buffer_i            (inv_buffer),
        .pc_jump_i                      (pc_jump),
        .exe_is_branch_i                (exe_is_branch),
        .exe_pc_i                       (exe_pc),
        .exe_taken_i                    (exe_taken),
        .exe_target_i                   (exe_target),
        .icache_req_valid_o             (req_valid),
        .icache_req_vaddr_o             (req_vaddr),
        .icache_req_invalidate_icache_o (req_inv_icache),
        .icache_req_invalidate_buffer_o (req_inv_buffer),
        .icache_resp_valid_i            (resp_valid),
        .icache_resp_data_i             (resp_data),
        .icache_resp_access_fault_i     (resp_access_fault),
        .icache_resp_page_fault_i       (resp_page_fault),
        .fetch_valid_o                  (fetch_valid),
        .fetch_pc_o                     (fetch_pc),
        .fetch_inst_o                   (fetch_inst),
        .fetch_ex_valid_o               (fetch_ex_valid),
        .fetch_ex_cause_o               (fetch_ex_cause),
        .fetch_ex_origin_o              (fetch_ex_origin),
        .fetch_bpred_taken_o            (bpred_taken),
        .fetch_bpred_target_o           (bpred_target)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // run limit from the test lengths
    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("watchdog timeout: the tests did not finish in time");
        $display("Simulation finished: FAIL");
        $fatal(1, "timeout");
    end

    task automatic stop_on_error(input string what);
        $display("%s", what);
        $display("Simulation finished: FAIL");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_addr(input string name, input logic [63:0] act, input logic [63:0] exp);
        if (act !== exp) begin
            stop_on_error($sformatf("CHECK FAILED %s: got 0x%h expected 0x%h", name, act, exp));
        end
    endtask

    task automatic check_inst(input string name, input logic [31:0] act, input logic [31:0] exp);
        if (act !== exp) begin
            stop_on_error($sformatf("CHECK FAILED %s: got 0x%h expected 0x%h", name, act, exp));
        end
    endtask

    task automatic check_cause(input string name, input riscv_pkg::exc_cause_e act,
                               input riscv_pkg::exc_cause_e exp);
        if (act !== exp) begin
            stop_on_error($sformatf("CHECK FAILED %s: got 0x%h expected 0x%h", name, act, exp));
        end
    endtask

    task automatic check_flag(input string name, input logic act, input logic exp);
        if (act !== exp) begin
            stop_on_error($sformatf("CHECK FAILED %s: got 0x%h expected 0x%h", name, act, exp));
        end
    endtask

    // next pc as the select rule gives it, illegal code steps by 4
    function automatic logic [63:0] expected_next_pc(input logic [63:0] pc,
                                                     input fetch_pkg::next_pc_sel_e sel,
                                                     input logic [63:0] jump);
        case (sel)
            fetch_pkg::NEXT_PC_SEL_PC:   return pc;
            fetch_pkg::NEXT_PC_SEL_JUMP: return jump;
            default:                     return pc + 64'd4;
        endcase
    endfunction

    function automatic logic [63:0] random_aligned_pc();
        logic [63:0] v;
        v = {$urandom, $urandom};
        v[1:0] = 2'b00;
        return v;
    endfunction

    function automatic fetch_pkg::next_pc_sel_e random_select();
        case ($urandom_range(0, 2))
            0:       return fetch_pkg::NEXT_PC_SEL_PC_4;
            1:       return fetch_pkg::NEXT_PC_SEL_PC;
            default: return fetch_pkg::NEXT_PC_SEL_JUMP;
        endcase
    endfunction

    // predictor index, pc bits just above the byte offset
    function automatic logic [IDX_WIDTH-1:0] bpred_index(input logic [63:0] pc);
        return pc[2 +: IDX_WIDTH];
    endfunction

    // present one select, let the pc load it, then go back to hold
    task automatic advance_pc(input fetch_pkg::next_pc_sel_e sel, input logic [63:0] jump);
        @(posedge clk);
        next_pc_sel <= sel;
        pc_jump     <= jump;
        @(posedge clk);
        next_pc_sel <= fetch_pkg::NEXT_PC_SEL_PC;
        ref_pc = expected_next_pc(ref_pc, sel, jump);
        @(negedge clk);
        check_addr("fetch_pc_o", fetch_pc, ref_pc);
    endtask

    // one held cycle with new stall, invalidate and icache model values
    task automatic apply_side_inputs(input logic stall_v, input logic inv_i_v, input logic inv_b_v,
                                     input logic valid_v, input logic af_v, input logic pf_v);
        @(posedge clk);
        stall              <= stall_v;
        inv_icache         <= inv_i_v;
        inv_buffer         <= inv_b_v;
        cache_valid        <= valid_v;
        cache_access_fault <= af_v;
        cache_page_fault   <= pf_v;
        @(negedge clk);
    endtask

    task automatic test_pc_sequencing();
        fetch_pkg::next_pc_sel_e sel;
        check_addr("fetch_pc_o", fetch_pc, RESET_PC);
        for (int i = 0; i < N_SEQ; i++) begin
            sel = random_select();
            advance_pc(sel, random_aligned_pc());
        end
    endtask

    task automatic test_icache_request();
        logic [63:0] target;
        logic        stall_v;
        logic        inv_i_v;
        logic        inv_b_v;
        for (int i = 0; i < N_REQ; i++) begin
            target = random_aligned_pc();
            // about half the targets misaligned
            if ($urandom_range(0, 1) == 1) begin
                target[1:0] = 2'($urandom_range(1, 3));
            end
            advance_pc(fetch_pkg::NEXT_PC_SEL_JUMP, target);
            stall_v = 1'($urandom_range(0, 1));
            inv_i_v = 1'($urandom_range(0, 1));
            inv_b_v = 1'($urandom_range(0, 1));
            apply_side_inputs(stall_v, inv_i_v, inv_b_v, 1'b0, 1'b0, 1'b0);
            check_flag("icache_req_valid_o", req_valid, (ref_pc[1:0] == 2'b00) && !stall_v);
            check_addr("icache_req_vaddr_o", {24'd0, req_vaddr}, {24'd0, ref_pc[39:0]});
            check_flag("icache_req_invalidate_icache_o", req_inv_icache, inv_i_v);
            check_flag("icache_req_invalidate_buffer_o", req_inv_buffer, inv_b_v);
        end
        apply_side_inputs(1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
    endtask

    task automatic test_fetch_data();
        for (int i = 0; i < N_DATA; i++) begin
            if (i % 4 == 0) begin
                advance_pc(fetch_pkg::NEXT_PC_SEL_JUMP, random_aligned_pc());
            end else begin
                advance_pc(fetch_pkg::NEXT_PC_SEL_PC_4, 64'd0);
            end
            // icache answers without faults
            apply_side_inputs(1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0);
            check_flag("fetch_valid_o", fetch_valid, 1'b1);
            check_flag("fetch_ex_valid_o", fetch_ex_valid, 1'b0);
            check_inst("fetch_inst_o", fetch_inst, icache_mem[ref_pc[5:2]]);
            // no answer, aligned pc, so nothing goes to decode
            apply_side_inputs(1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
            check_flag("fetch_valid_o", fetch_valid, 1'b0);
            check_flag("fetch_ex_valid_o", fetch_ex_valid, 1'b0);
        end
    endtask

    task automatic test_exception_priority();
        logic [63:0]           target;
        logic                  mis;
        logic                  af;
        logic                  pf;
        logic                  valid_v;
        logic                  exp_ex;
        riscv_pkg::exc_cause_e exp_cause;
        for (int combo = 0; combo < 16; combo++) begin
            valid_v = combo[3];
            mis     = combo[2];
            af      = combo[1];
            pf      = combo[0];
            target  = random_aligned_pc();
            if (mis) begin
                target[1:0] = 2'b10;
            end
            advance_pc(fetch_pkg::NEXT_PC_SEL_JUMP, target);
            apply_side_inputs(1'b0, 1'b0, 1'b0, valid_v, af, pf);
            // faults only count with a valid response
            exp_ex = mis | (valid_v & af) | (valid_v & pf);
            if (mis) begin
                exp_cause = riscv_pkg::INSTR_ADDR_MISALIGNED;
            end else if (valid_v && af) begin
                exp_cause = riscv_pkg::INSTR_ACCESS_FAULT;
            end else begin
                exp_cause = riscv_pkg::INSTR_PAGE_FAULT;
            end
            check_flag("fetch_ex_valid_o", fetch_ex_valid, exp_ex);
            check_flag("fetch_valid_o", fetch_valid, valid_v | exp_ex);
            if (exp_ex) begin
                check_cause("fetch_ex_cause_o", fetch_ex_cause, exp_cause);
                check_addr("fetch_ex_origin_o", fetch_ex_origin, ref_pc);
            end
        end
        apply_side_inputs(1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
    endtask

    // strobe execute and jump fetch to lookup_pc in the same cycle, check one cycle later
    task automatic train_and_lookup(input logic [63:0] pc, input logic taken,
                                    input logic [63:0] target, input logic [63:0] lookup_pc);
        logic [IDX_WIDTH-1:0] idx;
        @(posedge clk);
        exe_is_branch <= 1'b1;
        exe_pc        <= pc;
        exe_taken     <= taken;
        exe_target    <= target;
        next_pc_sel   <= fetch_pkg::NEXT_PC_SEL_JUMP;
        pc_jump       <= lookup_pc;
        @(posedge clk);
        exe_is_branch <= 1'b0;
        next_pc_sel   <= fetch_pkg::NEXT_PC_SEL_PC;
        // saturating counter rule, target only written when taken
        idx = bpred_index(pc);
        if (taken) begin
            if (ref_cnt[idx] != 2'b11) begin
                ref_cnt[idx] = ref_cnt[idx] + 2'd1;
            end
            ref_tgt[idx] = target;
        end else if (ref_cnt[idx] != 2'b00) begin
            ref_cnt[idx] = ref_cnt[idx] - 2'd1;
        end
        ref_pc = lookup_pc;
        @(negedge clk);
        idx = bpred_index(lookup_pc);
        check_addr("fetch_pc_o", fetch_pc, ref_pc);
        check_flag("fetch_bpred_taken_o", bpred_taken, ref_cnt[idx][1]);
        check_addr("fetch_bpred_target_o", bpred_target, ref_tgt[idx]);
    endtask

    task automatic test_branch_prediction();
        logic [63:0] base_pcs [4];
        logic [63:0] base;
        int unsigned slot;
        int unsigned run_len;
        logic        taken;
        // untrained table predicts not taken everywhere
        base = random_aligned_pc() & ~(ALIAS_STRIDE - 64'd1);
        advance_pc(fetch_pkg::NEXT_PC_SEL_JUMP, base);
        for (int i = 0; i < ENTRIES; i++) begin
            check_flag("fetch_bpred_taken_o", bpred_taken, ref_cnt[bpred_index(ref_pc)][1]);
            check_addr("fetch_bpred_target_o", bpred_target, ref_tgt[bpred_index(ref_pc)]);
            advance_pc(fetch_pkg::NEXT_PC_SEL_PC_4, 64'd0);
        end
        for (int i = 0; i < 4; i++) begin
            base_pcs[i] = random_aligned_pc();
        end
        // runs of one direction push counters to either end, aliases share an index
        for (int r = 0; r < N_RUNS; r++) begin
            slot    = $urandom_range(0, 3);
            taken   = 1'($urandom_range(0, 1));
            run_len = $urandom_range(1, 5);
            for (int k = 0; k < int'(run_len); k++) begin
                train_and_lookup(base_pcs[slot] + 64'($urandom_range(0, 3)) * ALIAS_STRIDE,
                                 taken, random_aligned_pc(),
                                 base_pcs[slot] + 64'($urandom_range(0, 3)) * ALIAS_STRIDE);
            end
        end
    endtask

    initial begin
        void'($urandom(67));
        rstn               = 1'b0;
        stall              = 1'b0;
        next_pc_sel        = fetch_pkg::NEXT_PC_SEL_PC;
        inv_icache         = 1'b0;
        inv_buffer         = 1'b0;
        pc_jump            = 64'd0;
        exe_is_branch      = 1'b0;
        exe_pc             = 64'd0;
        exe_taken          = 1'b0;
        exe_target         = 64'd0;
        cache_valid        = 1'b0;
        cache_access_fault = 1'b0;
        cache_page_fault   = 1'b0;
        // instruction word pattern over the whole word index
        for (int i = 0; i < ICACHE_WORDS; i++) begin
            icache_mem[i] = 32'h0000_0013 ^ (32'(i) * 32'h9e37_79b1);
        end
        // predictor reset state, weakly not taken with zero targets
        for (int i = 0; i < ENTRIES; i++) begin
            ref_cnt[i] = 2'b01;
            ref_tgt[i] = 64'd0;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        rstn <= 1'b1;
        ref_pc = RESET_PC;
        @(negedge clk);
        check_flag("icache_req_valid_o", req_valid, 1'b1);
        check_flag("fetch_ex_valid_o", fetch_ex_valid, 1'b0);

        test_pc_sequencing();
        test_icache_request();
        test_fetch_data();
        test_exception_priority();
        test_branch_prediction();

        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

// File: sources.f
hdl/riscv_pkg.sv
hdl/fetch_pkg.sv
hdl/branch_predictor.sv
hdl/if_stage.sv
hdl/fetch_top.sv
testbench/tb_fetch_top.sv

// File: Makefile
# Verilator build and run of the fetch subsystem testbench

VERILATOR ?= verilator
TOP       ?= tb_fetch_top
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

FAIL_MSG = Simulation finished: FAIL
PASS_MSG = Simulation finished: PASS

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list targets and variables"
	@echo "  test   build with verilator, run the testbench, search $(LOG) for failure"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "test failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "run ended without result"; exit 1; fi
	@echo "test passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
